// File: include/expipe_consts.svh
// Sizing constants of the execution pipeline
// RS_IDX_W must equal clog2(RS_DEPTH), and N_EU is fixed at 2 by the 1-bit unit id
`ifndef EXPIPE_CONSTS_SVH
`define EXPIPE_CONSTS_SVH

// Data word width
`define XLEN_W 64

// Unit control code width
`define EU_CTL_W 4

// Exception code width
`define EXCEPT_W 2

// Entries per reservation station
`define RS_DEPTH 8

// Entry index width
`define RS_IDX_W 3

// Units sharing the CDB
`define N_EU 2

`endif

// File: len5_exec.f
+incdir+include
source/len5_pkg.sv
source/expipe_pkg.sv
source/generic_rs.sv
source/alu_unit.sv
source/simd_unit.sv
source/cdb_arbiter.sv
source/len5_exec_top.sv
verif/tb_clkgen.sv
verif/tb_len5_exec.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execution stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f len5_exec.f \
    --top-module tb_len5_exec \
    --Mdir obj_dir \
    -o sim_len5_exec

./obj_dir/sim_len5_exec | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: source/alu_unit.sv
// Single-cycle scalar ALU with one result register toward the CDB arbiter
// Shifts use the low bits of rs2 only, illegal codes return zero with an exception
`timescale 1ns/10ps
`include "expipe_consts.svh"

module alu_unit (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // From the RS
    input  logic                   disp_valid_i,
    input  expipe_pkg::alu_issue_t disp_payload_i,
    input  expipe_pkg::rs_idx_t    disp_idx_i,
    output logic                   disp_ready_o,
    // To the arbiter
    output logic                   res_valid_o,
    output expipe_pkg::eu_result_t res_o,
    input  logic                   grant_i
);

    import len5_pkg::*;
    import expipe_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN_W);

    xlen_t               rs1;
    xlen_t               rs2;
    logic [SHAMT_W-1:0]  shamt;
    eu_result_t          res_d;
    logic                accept;

    assign rs1   = disp_payload_i.rs1;
    assign rs2   = disp_payload_i.rs2;
    assign shamt = rs2[SHAMT_W-1:0];

    // Free slot, or the held result leaves this cycle
    assign disp_ready_o = !res_valid_o || grant_i;
    assign accept       = disp_valid_i && disp_ready_o;

    always_comb begin
        res_d.idx           = disp_idx_i;
        res_d.result        = '0;
        res_d.except_raised = 1'b0;
        res_d.except_code   = EXC_NONE;
        case (disp_payload_i.ctl)
            ADD: res_d.result = rs1 + rs2;
            SUB: res_d.result = rs1 - rs2;
            AND: res_d.result = rs1 & rs2;
            OR:  res_d.result = rs1 | rs2;
            XOR: res_d.result = rs1 ^ rs2;
            SLL: res_d.result = rs1 << shamt;
            SRL: res_d.result = rs1 >> shamt;
            // Signed compare, 1 or 0
            SLT: res_d.result = xlen_t'($signed(rs1) < $signed(rs2));
            default: begin
                res_d.except_raised = 1'b1;
                res_d.except_code   = ILLEGAL_CTL;
            end
        endcase
    end

    // Valid held until granted, a new accept refills it on the same edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else if (flush_i) begin
            res_valid_o <= 1'b0;
        end else if (accept) begin
            res_valid_o <= 1'b1;
        end else if (grant_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_o <= res_d;
        end
    end

endmodule

// File: source/cdb_arbiter.sv
// Two-way round-robin CDB arbiter, grant is combinational and the packet registered
// The CDB has no back-pressure, so every granted result is broadcast
`timescale 1ns/10ps
`include "expipe_consts.svh"

module cdb_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic [`N_EU-1:0]       req_i,
    input  expipe_pkg::eu_result_t res_alu_i,
    input  expipe_pkg::eu_result_t res_simd_i,
    output logic [`N_EU-1:0]       grant_o,
    output logic                   cdb_valid_o,
    output expipe_pkg::cdb_pkt_t   cdb_o
);

    import expipe_pkg::*;

    // Unit granted most recently
    logic last_q;
    // Winning unit id, 1 is SIMD
    logic win;
    logic any_req;

    assign any_req = |req_i;

    // On contention the unit not granted last wins
    assign win     = (req_i[0] && req_i[1]) ? !last_q : req_i[1];
    assign grant_o = {req_i[1] && win, req_i[0] && !win};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
            last_q      <= 1'b0;
        end else if (flush_i) begin
            cdb_valid_o <= 1'b0;
            last_q      <= 1'b0;
        end else begin
            cdb_valid_o <= any_req;
            if (any_req) begin
                last_q <= win;
            end
        end
    end

    // Packet tagged with the winner id
    always_ff @(posedge clk_i) begin
        if (any_req) begin
            cdb_o.eu_id <= win;
            cdb_o.res   <= win ? res_simd_i : res_alu_i;
        end
    end

endmodule

// File: source/expipe_pkg.sv
// Execution pipeline types shared by the RS, the units and the CDB
// Control fields use enums, but any 4-bit value can be driven in
`include "expipe_consts.svh"

package expipe_pkg;

    import len5_pkg::*;

    // Entry index inside one RS
    typedef logic [`RS_IDX_W-1:0] rs_idx_t;

    // Scalar ALU codes, 8 to 15 are illegal
    typedef enum logic [`EU_CTL_W-1:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SLT = 4'd7
    } alu_op_t;

    // SIMD codes, 5 to 15 are illegal
    typedef enum logic [`EU_CTL_W-1:0] {
        VADD = 4'd0,
        VSUB = 4'd1,
        VMIN = 4'd2,
        VMAX = 4'd3,
        VSEL = 4'd4
    } simd_op_t;

    typedef enum logic [`EXCEPT_W-1:0] {
        EXC_NONE    = 2'd0,
        ILLEGAL_CTL = 2'd1
    } exc_code_t;

    // Issue payload of the ALU RS
    typedef struct packed {
        alu_op_t ctl;
        xlen_t   rs1;
        xlen_t   rs2;
    } alu_issue_t;

    // Issue payload of the SIMD RS
    typedef struct packed {
        simd_op_t ctl;
        lane_sz_t lane_sz;
        xlen_t    rs1;
        xlen_t    rs2;
    } simd_issue_t;

    // Result of one unit, tagged with its RS entry
    typedef struct packed {
        rs_idx_t   idx;
        xlen_t     result;
        logic      except_raised;
        exc_code_t except_code;
    } eu_result_t;

    // CDB broadcast, unit id 0 is the ALU and 1 the SIMD unit
    typedef struct packed {
        logic       eu_id;
        eu_result_t res;
    } cdb_pkt_t;

endpackage

// File: source/generic_rs.sv
// Reservation station for operands that are already ready, no wakeup or tag match
// Dispatch is strictly in issue order, an entry is freed only by its own CDB packet
`timescale 1ns/10ps
`include "expipe_consts.svh"

module generic_rs #(
    parameter type         T_PAYLOAD = logic,
    parameter int unsigned DEPTH     = `RS_DEPTH,
    parameter bit          EU_ID     = 1'b0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    // Issue side
    input  logic                 iss_valid_i,
    output logic                 iss_ready_o,
    input  T_PAYLOAD             iss_payload_i,
    // Dispatch side
    output logic                 disp_valid_o,
    output T_PAYLOAD             disp_payload_o,
    output expipe_pkg::rs_idx_t  disp_idx_o,
    input  logic                 disp_ready_i,
    // CDB snoop
    input  logic                 cdb_valid_i,
    input  expipe_pkg::cdb_pkt_t cdb_i
);

    import expipe_pkg::*;

    // Per-entry state
    logic [DEPTH-1:0] busy_q;
    logic [DEPTH-1:0] sent_q;
    T_PAYLOAD         payload_q [DEPTH];
    rs_idx_t          stamp_q [DEPTH];

    // Allocation and dispatch counters give the age order
    rs_idx_t alloc_cnt_q;
    rs_idx_t disp_cnt_q;

    logic    free_found;
    rs_idx_t alloc_idx;
    logic    disp_found;
    rs_idx_t disp_sel;
    logic    iss_fire;
    logic    disp_fire;
    logic    cdb_free;

    // Lowest free index
    always_comb begin
        free_found = 1'b0;
        alloc_idx  = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_found = 1'b1;
                alloc_idx  = rs_idx_t'(i);
            end
        end
    end

    // Oldest waiting entry carries the stamp the dispatch counter expects
    // Live stamps are unique because at most DEPTH entries exist
    always_comb begin
        disp_found = 1'b0;
        disp_sel   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (busy_q[i] && !sent_q[i] && stamp_q[i] == disp_cnt_q) begin
                disp_found = 1'b1;
                disp_sel   = rs_idx_t'(i);
            end
        end
    end

    assign iss_ready_o    = free_found && !flush_i;
    assign iss_fire       = iss_valid_i && iss_ready_o;
    assign disp_valid_o   = disp_found;
    assign disp_payload_o = payload_q[disp_sel];
    assign disp_idx_o     = disp_sel;
    assign disp_fire      = disp_valid_o && disp_ready_i;
    assign cdb_free       = cdb_valid_i && (cdb_i.eu_id == EU_ID);

    // Control state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q      <= '0;
            sent_q      <= '0;
            alloc_cnt_q <= '0;
            disp_cnt_q  <= '0;
        end else if (flush_i) begin
            busy_q      <= '0;
            sent_q      <= '0;
            alloc_cnt_q <= '0;
            disp_cnt_q  <= '0;
        end else begin
            // Result broadcast releases the entry
            if (cdb_free) begin
                busy_q[cdb_i.res.idx] <= 1'b0;
                sent_q[cdb_i.res.idx] <= 1'b0;
            end
            // New entry, only ever a free index
            if (iss_fire) begin
                busy_q[alloc_idx] <= 1'b1;
                sent_q[alloc_idx] <= 1'b0;
                alloc_cnt_q       <= alloc_cnt_q + 1'b1;
            end
            if (disp_fire) begin
                sent_q[disp_sel] <= 1'b1;
                disp_cnt_q       <= disp_cnt_q + 1'b1;
            end
        end
    end

    // Entry contents, only read while the entry is busy
    always_ff @(posedge clk_i) begin
        if (iss_fire) begin
            payload_q[alloc_idx] <= iss_payload_i;
            stamp_q[alloc_idx]   <= alloc_cnt_q;
        end
    end

endmodule

// File: source/len5_exec_top.sv
// Execution stage with ALU and SIMD units sharing one CDB
// Issued instructions must already have both operands
`timescale 1ns/10ps
`include "expipe_consts.svh"

module len5_exec_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    // ALU issue
    input  logic                    alu_iss_valid_i,
    input  expipe_pkg::alu_issue_t  alu_iss_payload_i,
    output logic                    alu_iss_ready_o,
    // SIMD issue
    input  logic                    simd_iss_valid_i,
    input  expipe_pkg::simd_issue_t simd_iss_payload_i,
    output logic                    simd_iss_ready_o,
    // Result broadcast
    output logic                    cdb_valid_o,
    output expipe_pkg::cdb_pkt_t    cdb_o
);

    import expipe_pkg::*;

    // ALU dispatch path
    logic        alu_disp_valid;
    alu_issue_t  alu_disp_payload;
    rs_idx_t     alu_disp_idx;
    logic        alu_disp_ready;
    eu_result_t  alu_res;

    // SIMD dispatch path
    logic        simd_disp_valid;
    simd_issue_t simd_disp_payload;
    rs_idx_t     simd_disp_idx;
    logic        simd_disp_ready;
    eu_result_t  simd_res;

    // Bit 0 is the ALU, bit 1 the SIMD unit
    logic [`N_EU-1:0] req;
    logic [`N_EU-1:0] grant;

    generic_rs #(
        .T_PAYLOAD (alu_issue_t),
        .EU_ID     (1'b0)
    ) u_alu_rs (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .iss_valid_i    (alu_iss_valid_i),
        .iss_ready_o    (alu_iss_ready_o),
        .iss_payload_i  (alu_iss_payload_i),
        .disp_valid_o   (alu_disp_valid),
        .disp_payload_o (alu_disp_payload),
        .disp_idx_o     (alu_disp_idx),
        .disp_ready_i   (alu_disp_ready),
        .cdb_valid_i    (cdb_valid_o),
        .cdb_i          (cdb_o)
    );

    generic_rs #(
        .T_PAYLOAD (simd_issue_t),
        .EU_ID     (1'b1)
    ) u_simd_rs (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .iss_valid_i    (simd_iss_valid_i),
        .iss_ready_o    (simd_iss_ready_o),
        .iss_payload_i  (simd_iss_payload_i),
        .disp_valid_o   (simd_disp_valid),
        .disp_payload_o (simd_disp_payload),
        .disp_idx_o     (simd_disp_idx),
        .disp_ready_i   (simd_disp_ready),
        .cdb_valid_i    (cdb_valid_o),
        .cdb_i          (cdb_o)
    );

    alu_unit u_alu (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .disp_valid_i   (alu_disp_valid),
        .disp_payload_i (alu_disp_payload),
        .disp_idx_i     (alu_disp_idx),
        .disp_ready_o   (alu_disp_ready),
        .res_valid_o    (req[0]),
        .res_o          (alu_res),
        .grant_i        (grant[0])
    );

    simd_unit u_simd (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .disp_valid_i   (simd_disp_valid),
        .disp_payload_i (simd_disp_payload),
        .disp_idx_i     (simd_disp_idx),
        .disp_ready_o   (simd_disp_ready),
        .res_valid_o    (req[1]),
        .res_o          (simd_res),
        .grant_i        (grant[1])
    );

    cdb_arbiter u_arb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .req_i       (req),
        .res_alu_i   (alu_res),
        .res_simd_i  (simd_res),
        .grant_o     (grant),
        .cdb_valid_o (cdb_valid_o),
        .cdb_o       (cdb_o)
    );

endmodule

// File: source/len5_pkg.sv
// Core-wide base types
// Data width comes from the shared constants header
`include "expipe_consts.svh"

package len5_pkg;

    // One data word
    typedef logic [`XLEN_W-1:0] xlen_t;

    // SIMD lane size
    typedef enum logic [1:0] {
        LANE_8  = 2'd0,
        LANE_16 = 2'd1,
        LANE_32 = 2'd2,
        LANE_64 = 2'd3
    } lane_sz_t;

endpackage

// File: source/simd_unit.sv
// Packed-SIMD unit, lanewise on 8, 16, 32 or 64-bit lanes in one cycle
// Add and sub wrap per lane, min and max are signed, illegal codes return zero
`timescale 1ns/10ps
`include "expipe_consts.svh"

module simd_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    // From the RS
    input  logic                    disp_valid_i,
    input  expipe_pkg::simd_issue_t disp_payload_i,
    input  expipe_pkg::rs_idx_t     disp_idx_i,
    output logic                    disp_ready_o,
    // To the arbiter
    output logic                    res_valid_o,
    output expipe_pkg::eu_result_t  res_o,
    input  logic                    grant_i
);

    import len5_pkg::*;
    import expipe_pkg::*;

    // One result per lane size, picked by lane_sz
    logic [3:0][`XLEN_W-1:0] lane_res;
    logic                    legal;
    eu_result_t              res_d;
    logic                    accept;

    // Lanes arrive sign-extended, so one 64-bit body serves every size
    // Truncating the sum back to the lane gives the wrap
    function automatic xlen_t lane_calc(simd_op_t op, longint a, longint b);
        case (op)
            VADD:    return xlen_t'(a + b);
            VSUB:    return xlen_t'(a - b);
            VMIN:    return xlen_t'((a < b) ? a : b);
            VMAX:    return xlen_t'((a > b) ? a : b);
            // Keep rs1 lane where the rs2 lane is nonzero
            VSEL:    return xlen_t'((b != 0) ? a : 0);
            default: return '0;
        endcase
    endfunction

    for (genvar s = 0; s < 4; s++) begin : g_size
        localparam int W = 8 << s;
        for (genvar l = 0; l < `XLEN_W / W; l++) begin : g_lane
            logic signed [W-1:0] a_l;
            logic signed [W-1:0] b_l;
            xlen_t               full;

            assign a_l  = disp_payload_i.rs1[l*W +: W];
            assign b_l  = disp_payload_i.rs2[l*W +: W];
            assign full = lane_calc(disp_payload_i.ctl, 64'(a_l), 64'(b_l));
            assign lane_res[s][l*W +: W] = full[W-1:0];
        end
    end

    assign legal = disp_payload_i.ctl inside {VADD, VSUB, VMIN, VMAX, VSEL};

    always_comb begin
        res_d.idx           = disp_idx_i;
        res_d.result        = legal ? lane_res[disp_payload_i.lane_sz] : '0;
        res_d.except_raised = !legal;
        res_d.except_code   = legal ? EXC_NONE : ILLEGAL_CTL;
    end

    // Same accept and hold rules as the ALU
    assign disp_ready_o = !res_valid_o || grant_i;
    assign accept       = disp_valid_i && disp_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else if (flush_i) begin
            res_valid_o <= 1'b0;
        end else if (accept) begin
            res_valid_o <= 1'b1;
        end else if (grant_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_o <= res_d;
        end
    end

endmodule

// File: verif/tb_clkgen.sv
// Testbench clock and reset source, 8 ns period
// Reset is held low for 4 rising edges and released just after a rising edge
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: verif/tb_len5_exec.sv
// Testbench for the execution stage with inputs changing on the falling edge only
// Expected results come from a lane and scalar model written from the ISA rules
`timescale 1ns/10ps
`include "expipe_consts.svh"

module tb_len5_exec;

    import len5_pkg::*;
    import expipe_pkg::*;

    localparam int DEPTH    = `RS_DEPTH;
    localparam int MAX_WAIT = 200;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        alu_valid;
    alu_issue_t  alu_pay;
    logic        alu_ready;
    logic        simd_valid;
    simd_issue_t simd_pay;
    logic        simd_ready;
    logic        cdb_valid;
    cdb_pkt_t    cdb;

    integer seed = 8301;
    int     chk_errs;
    int     prop_errs;
    int     packets;

    // Model of both RS with index 0 on the ALU side
    logic [DEPTH-1:0] busy_m [2];
    logic [DEPTH-1:0] free_next [2];
    logic [DEPTH-1:0] pending [2];
    xlen_t            exp_res [2][DEPTH];
    logic             exp_exc [2][DEPTH];
    logic             saw_full [2];

    tb_clkgen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    len5_exec_top dut (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .flush_i            (flush),
        .alu_iss_valid_i    (alu_valid),
        .alu_iss_payload_i  (alu_pay),
        .alu_iss_ready_o    (alu_ready),
        .simd_iss_valid_i   (simd_valid),
        .simd_iss_payload_i (simd_pay),
        .simd_iss_ready_o   (simd_ready),
        .cdb_valid_o        (cdb_valid),
        .cdb_o              (cdb)
    );

    // A waiting result stays put until its grant
    a_alu_hold: assert property (@(posedge clk) disable iff (!rst_n || flush)
        (dut.req[0] && !dut.grant[0]) |=> (dut.req[0] && $stable(dut.alu_res)))
        else begin
            prop_errs++;
            $display("ALU result dropped or changed before its grant at %0t", $time);
        end

    a_simd_hold: assert property (@(posedge clk) disable iff (!rst_n || flush)
        (dut.req[1] && !dut.grant[1]) |=> (dut.req[1] && $stable(dut.simd_res)))
        else begin
            prop_errs++;
            $display("SIMD result dropped or changed before its grant at %0t", $time);
        end

    // A round robin loser gets the next slot
    a_rr_simd: assert property (@(posedge clk) disable iff (!rst_n || flush)
        (dut.req == 2'b11 && dut.grant[0]) |=> dut.grant[1])
        else begin
            prop_errs++;
            $display("SIMD unit waited more than one extra cycle at %0t", $time);
        end

    a_rr_alu: assert property (@(posedge clk) disable iff (!rst_n || flush)
        (dut.req == 2'b11 && dut.grant[1]) |=> dut.grant[0])
        else begin
            prop_errs++;
            $display("ALU waited more than one extra cycle at %0t", $time);
        end

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !cdb_valid)
        else begin
            prop_errs++;
            $display("CDB packet right after a flush at %0t", $time);
        end

    function automatic int unsigned urand();
        return $random(seed);
    endfunction

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // Scalar model with bit 64 flagging an illegal code
    function automatic logic [64:0] ref_alu(logic [3:0] op, xlen_t a, xlen_t b);
        case (op)
            ADD:     return {1'b0, a + b};
            SUB:     return {1'b0, a - b};
            AND:     return {1'b0, a & b};
            OR:      return {1'b0, a | b};
            XOR:     return {1'b0, a ^ b};
            SLL:     return {1'b0, a << b[5:0]};
            SRL:     return {1'b0, a >> b[5:0]};
            SLT:     return {1'b0, 63'd0, $signed(a) < $signed(b)};
            default: return {1'b1, 64'd0};
        endcase
    endfunction

    // Lane model that pulls out each lane and sign extends it by shifts
    function automatic logic [64:0] ref_simd(logic [3:0] op, logic [1:0] sz,
                                             xlen_t a, xlen_t b);
        int     w;
        xlen_t  mask;
        xlen_t  res;
        xlen_t  ua;
        xlen_t  ub;
        longint sa;
        longint sb;
        longint r;
        w    = 8 << sz;
        mask = (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
        res  = '0;
        if (op > 4'd4) begin
            return {1'b1, 64'd0};
        end
        for (int l = 0; l < 64 / w; l++) begin
            ua = (a >> (l * w)) & mask;
            ub = (b >> (l * w)) & mask;
            sa = $signed(ua << (64 - w)) >>> (64 - w);
            sb = $signed(ub << (64 - w)) >>> (64 - w);
            case (op)
                VADD:    r = sa + sb;
                VSUB:    r = sa - sb;
                VMIN:    r = (sa < sb) ? sa : sb;
                VMAX:    r = (sa > sb) ? sa : sb;
                default: r = (ub != 0) ? sa : 64'sd0;
            endcase
            res = res | ((xlen_t'(r) & mask) << (l * w));
        end
        return {1'b0, res};
    endfunction

    // Random lanes forced to zero, so VSEL and equal compares get exercised
    function automatic xlen_t lane_mask(logic [1:0] sz);
        int    w;
        xlen_t m;
        w = 8 << sz;
        m = '0;
        for (int l = 0; l < 64 / w; l++) begin
            if (urand() % 2) begin
                m = m | (((w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1)) << (l * w));
            end
        end
        return m;
    endfunction

    function automatic alu_issue_t rand_alu(bit legal);
        alu_issue_t p;
        p.ctl = legal ? alu_op_t'(4'(urand() % 8)) : alu_op_t'(4'(8 + urand() % 8));
        p.rs1 = rand64();
        p.rs2 = rand64();
        return p;
    endfunction

    function automatic simd_issue_t rand_simd(bit legal, logic [1:0] sz);
        simd_issue_t p;
        p.ctl     = legal ? simd_op_t'(4'(urand() % 5)) : simd_op_t'(4'(5 + urand() % 11));
        p.lane_sz = lane_sz_t'(sz);
        p.rs1     = rand64();
        p.rs2     = rand64();
        if (urand() % 2) begin
            p.rs2 = p.rs2 & lane_mask(sz);
        end
        return p;
    endfunction

    function automatic int lowest_free(int u);
        for (int i = 0; i < DEPTH; i++) begin
            if (!busy_m[u][i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic give_up(string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic clear_model();
        for (int u = 0; u < 2; u++) begin
            busy_m[u]    = '0;
            free_next[u] = '0;
            pending[u]   = '0;
        end
    endtask

    // CDB is stable at the falling edge
    task automatic check_cdb();
        int u;
        int i;
        if (cdb_valid) begin
            u = int'(cdb.eu_id);
            i = int'(cdb.res.idx);
            packets++;
            assert (pending[u][i]) else begin
                chk_errs++;
                $display("Unexpected CDB packet for unit %0d entry %0d at %0t", u, i, $time);
            end
            assert (cdb.res.result == exp_res[u][i] &&
                    cdb.res.except_raised == exp_exc[u][i] &&
                    cdb.res.except_code == (exp_exc[u][i] ? ILLEGAL_CTL : EXC_NONE))
            else begin
                chk_errs++;
                $display("** Error at %0t: unit %0d entry %0d got %h exc %b, expected %h exc %b",
                         $time, u, i, cdb.res.result, cdb.res.except_raised,
                         exp_res[u][i], exp_exc[u][i]);
            end
            pending[u][i]   = 1'b0;
            free_next[u][i] = 1'b1;
        end
    endtask

    // Ready must follow the model occupancy
    task automatic check_ready();
        assert (alu_ready == (!(&busy_m[0]) && !flush)) else begin
            chk_errs++;
            $display("** Error at %0t: ALU ready %b with model busy %b", $time, alu_ready,
                     busy_m[0]);
        end
        assert (simd_ready == (!(&busy_m[1]) && !flush)) else begin
            chk_errs++;
            $display("** Error at %0t: SIMD ready %b with model busy %b", $time, simd_ready,
                     busy_m[1]);
        end
        if ((&busy_m[0]) && !alu_ready) begin
            saw_full[0] = 1'b1;
        end
        if ((&busy_m[1]) && !simd_ready) begin
            saw_full[1] = 1'b1;
        end
    endtask

    // One cycle where entries seen on the CDB last cycle become free after that edge
    task automatic step();
        @(negedge clk);
        busy_m[0]    = busy_m[0] & ~free_next[0];
        busy_m[1]    = busy_m[1] & ~free_next[1];
        free_next[0] = '0;
        free_next[1] = '0;
        check_cdb();
        check_ready();
    endtask

    // Offer to one or both RS and hold until each is taken
    task automatic drive_issue(bit do_a, alu_issue_t ap, bit do_s, simd_issue_t sp);
        bit          need_a;
        bit          need_s;
        int          idx;
        int          waited;
        logic [64:0] r;
        need_a   = do_a;
        need_s   = do_s;
        waited   = 0;
        alu_pay  = ap;
        simd_pay = sp;
        while (need_a || need_s) begin
            alu_valid  = need_a;
            simd_valid = need_s;
            if (need_a && alu_ready) begin
                idx = lowest_free(0);
                if (idx >= 0) begin
                    r                 = ref_alu(ap.ctl, ap.rs1, ap.rs2);
                    exp_res[0][idx]   = r[63:0];
                    exp_exc[0][idx]   = r[64];
                    pending[0][idx]   = 1'b1;
                    busy_m[0][idx]    = 1'b1;
                end
                need_a = 1'b0;
            end
            if (need_s && simd_ready) begin
                idx = lowest_free(1);
                if (idx >= 0) begin
                    r                 = ref_simd(sp.ctl, sp.lane_sz, sp.rs1, sp.rs2);
                    exp_res[1][idx]   = r[63:0];
                    exp_exc[1][idx]   = r[64];
                    pending[1][idx]   = 1'b1;
                    busy_m[1][idx]    = 1'b1;
                end
                need_s = 1'b0;
            end
            step();
            waited++;
            if (waited > MAX_WAIT) begin
                give_up("an issue handshake");
            end
        end
        alu_valid  = 1'b0;
        simd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((pending[0] | pending[1]) != '0) begin
            step();
            waited++;
            if (waited > MAX_WAIT) begin
                give_up("outstanding CDB packets");
            end
        end
    endtask

    initial begin
        int waited;
        alu_valid   = 1'b0;
        alu_pay     = '0;
        simd_valid  = 1'b0;
        simd_pay    = '0;
        flush       = 1'b0;
        chk_errs    = 0;
        prop_errs   = 0;
        packets     = 0;
        saw_full[0] = 1'b0;
        saw_full[1] = 1'b0;
        clear_model();

        waited = 0;
        while (!rst_n) begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                give_up("reset release");
            end
        end
        step();

        // Scalar ops alone
        repeat (40) drive_issue(1'b1, rand_alu(1'b1), 1'b0, '0);
        wait_drain();

        // Lanewise ops over every lane size
        for (int i = 0; i < 60; i++) begin
            drive_issue(1'b0, '0, 1'b1, rand_simd(1'b1, 2'(i % 4)));
        end
        wait_drain();

        // Illegal codes on both units
        for (int i = 0; i < 6; i++) begin
            drive_issue(1'b1, rand_alu(1'b0), 1'b1, rand_simd(1'b0, 2'(i % 4)));
        end
        wait_drain();

        // Both units every cycle fill the RS since the CDB takes one per cycle
        saw_full[0] = 1'b0;
        saw_full[1] = 1'b0;
        for (int i = 0; i < 48; i++) begin
            drive_issue(1'b1, rand_alu(1'b1), 1'b1, rand_simd(1'b1, 2'(urand() % 4)));
        end
        wait_drain();
        assert (saw_full[0] && saw_full[1]) else begin
            chk_errs++;
            $display("A reservation station never reported full under back-pressure");
        end

        // Flush with both RS filled up and work in flight
        for (int i = 0; i < 16; i++) begin
            drive_issue(1'b1, rand_alu(1'b1), 1'b1, rand_simd(1'b1, 2'(i % 4)));
        end
        flush = 1'b1;
        clear_model();
        step();
        flush = 1'b0;
        repeat (12) step();
        assert (alu_ready && simd_ready) else begin
            chk_errs++;
            $display("** Error at %0t: issue ready low after flush", $time);
        end

        $display("Checks done: %0d packets, %0d check errors, %0d assertion errors",
                 packets, chk_errs, prop_errs);
        if (chk_errs == 0 && prop_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
